// File: n_clic.f
+incdir+design
design/clic_pkg.sv
design/csr_reg.sv
design/clic_entry_bank.sv
design/clic_arbiter.sv
design/n_clic.sv
dv/tb_n_clic.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the n_clic testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_n_clic \
  -f n_clic.f \
  -o sim_n_clic

# the simulator exits non-zero on a fatal check, the log decides the verdict
./obj_dir/sim_n_clic > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
  echo "no verdict found in sim.log"
  exit 1
fi

// File: dv/tb_n_clic.sv
// seeded random test of n_clic, inputs change on the falling edge, stops at first mismatch
`default_nettype none
`timescale 1ns/1ns

`include "clic_consts.svh"

module tb_n_clic
  import clic_pkg::*;
();

  localparam int          VS             = `CLIC_VEC_SIZE;
  localparam int          VW             = `CLIC_VEC_WIDTH;
  localparam int          PW             = `CLIC_PRIO_WIDTH;
  localparam int          EN_BIT         = PW;
  localparam int          PEND_BIT       = PW + 1;
  // pended, enable and prio are the only stored bits
  localparam word         ENTRY_MASK     = (word'(1) << PEND_BIT) | (word'(1) << EN_BIT) |
                                           word'({PW{1'b1}});
  localparam csr_addr_t   BASE           = `CLIC_ENTRY_BASE_ADDR;
  localparam int unsigned SEED           = 32'h8e64_560d;
  localparam int          N_RANDOM       = 4000;
  // reset, directed reads and the random run fit well inside this
  localparam int          TIMEOUT_CYCLES = N_RANDOM + 1000;

  logic                 clk;
  logic                 arst_n;
  logic                 csr_enable;
  csr_addr_t            csr_addr;
  r                     rs1_zimm;
  word                  rs1_data;
  csr_op_t              csr_op;
  word                  out;
  logic [VS-1:0]        irq_src;
  logic                 irq_claim;
  logic                 irq;
  logic [VW-1:0]        irq_id;
  logic [PW-1:0]        irq_prio;

  // reference model state after the last rising edge
  word                  m_mstatus;
  word                  m_mintthresh;
  word                  m_stack_depth;
  word                  m_ent [VS];
  logic                 m_irq;
  logic [VW-1:0]        m_id;
  logic [PW-1:0]        m_prio;

  int                   cycle_count;
  int unsigned          seed_ret;

  n_clic u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .csr_enable(csr_enable),
    .csr_addr  (csr_addr),
    .rs1_zimm  (rs1_zimm),
    .rs1_data  (rs1_data),
    .csr_op    (csr_op),
    .out       (out),
    .irq_src   (irq_src),
    .irq_claim (irq_claim),
    .irq       (irq),
    .irq_id    (irq_id),
    .irq_prio  (irq_prio)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic check_word(input string name, input word got, input word exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_irq(input logic got_irq, input logic [`CLIC_VEC_WIDTH-1:0] got_id,
                           input logic [`CLIC_PRIO_WIDTH-1:0] got_prio, input logic exp_irq,
                           input logic [`CLIC_VEC_WIDTH-1:0] exp_id,
                           input logic [`CLIC_PRIO_WIDTH-1:0] exp_prio);
    if (got_irq !== exp_irq) begin
      $display("CHECK FAILED at %0t ns: irq got %b expected %b", $time, got_irq, exp_irq);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on irq");
    end
    if (got_id !== exp_id) begin
      $display("CHECK FAILED at %0t ns: irq_id got %0d expected %0d", $time, got_id, exp_id);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on irq_id");
    end
    if (got_prio !== exp_prio) begin
      $display("CHECK FAILED at %0t ns: irq_prio got %0d expected %0d", $time, got_prio,
               exp_prio);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on irq_prio");
    end
  endtask

  // what the csr read port should show for an address
  function automatic word model_read(csr_addr_t a);
    csr_addr_t off;
    off = a - BASE;
    if (a == `CLIC_MSTATUS_ADDR) return m_mstatus;
    if (a == `CLIC_MINTTHRESH_ADDR) return m_mintthresh;
    if (a == `CLIC_STACK_DEPTH_ADDR) return m_stack_depth;
    if (a >= BASE && off < csr_addr_t'(VS)) return m_ent[off[VW-1:0]];
    return '0;
  endfunction

  function automatic word model_operand(csr_op_t op, r zimm, word data);
    // immediate forms zero-extend the 5-bit field
    if (op == CSRRWI || op == CSRRSI || op == CSRRCI) return {27'd0, zimm};
    return data;
  endfunction

  function automatic logic model_writes(csr_op_t op, word opnd);
    if (op == CSRRW || op == CSRRWI) return 1'b1;
    if (op == CSR_NONE) return 1'b0;
    // set and clear with nothing to set or clear
    return opnd != '0;
  endfunction

  function automatic word model_apply(csr_op_t op, word old, word opnd);
    if (op == CSRRW || op == CSRRWI) return opnd;
    if (op == CSRRS || op == CSRRSI) return old | opnd;
    if (op == CSRRC || op == CSRRCI) return old & ~opnd;
    return old;
  endfunction

  task automatic check_outputs();
    check_word("out", out, model_read(csr_addr));
    check_irq(irq, irq_id, irq_prio, m_irq, m_id, m_prio);
  endtask

  // per cycle check what the last edge produced then drive inputs and advance the model
  task automatic step(input logic en, input csr_addr_t a, input csr_op_t op, input r zimm,
                      input word data, input logic [VS-1:0] src, input logic claim);
    word           opnd;
    logic          wr;
    csr_addr_t     off;
    logic          found;
    logic [VW-1:0] best_id;
    logic [PW-1:0] best_prio;
    logic          irq_next;
    word           ent_next [VS];
    @(negedge clk);
    check_outputs();
    csr_enable = en;
    csr_addr   = a;
    csr_op     = op;
    rs1_zimm   = zimm;
    rs1_data   = data;
    irq_src    = src;
    irq_claim  = claim;
    // downward scan where >= lets the lower index take a tie
    found     = 1'b0;
    best_id   = '0;
    best_prio = '0;
    for (int i = VS - 1; i >= 0; i--) begin
      if (m_ent[i][PEND_BIT] && m_ent[i][EN_BIT] &&
          (!found || m_ent[i][PW-1:0] >= best_prio)) begin
        found     = 1'b1;
        best_id   = VW'(i);
        best_prio = m_ent[i][PW-1:0];
      end
    end
    irq_next = found && m_mstatus[`CLIC_MIE_BIT] && (best_prio > m_mintthresh[PW-1:0]);
    opnd = model_operand(op, zimm, data);
    wr   = en && model_writes(op, opnd);
    off  = a - BASE;
    // claim clear, then source set, then csr write
    for (int i = 0; i < VS; i++) begin
      ent_next[i] = m_ent[i];
      if (claim && int'(m_id) == i) ent_next[i][PEND_BIT] = 1'b0;
      if (src[i]) ent_next[i][PEND_BIT] = 1'b1;
      if (wr && a >= BASE && off == csr_addr_t'(i)) begin
        ent_next[i] = model_apply(op, m_ent[i], opnd) & ENTRY_MASK;
      end
    end
    if (wr && a == `CLIC_MSTATUS_ADDR) m_mstatus = model_apply(op, m_mstatus, opnd);
    if (wr && a == `CLIC_MINTTHRESH_ADDR) m_mintthresh = model_apply(op, m_mintthresh, opnd);
    for (int i = 0; i < VS; i++) begin
      m_ent[i] = ent_next[i];
    end
    // id and prio hold while irq is low
    m_irq = irq_next;
    if (irq_next) begin
      m_id   = best_id;
      m_prio = best_prio;
    end
  endtask

  task automatic random_op();
    csr_op_t       ops [6];
    logic          en;
    csr_addr_t     a;
    r              zimm;
    word           data;
    logic [VS-1:0] src;
    logic          claim;
    ops = '{CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI};
    en  = 1'($urandom_range(0, 1));
    case ($urandom_range(0, 9))
      0: a = `CLIC_MSTATUS_ADDR;
      1: a = `CLIC_MINTTHRESH_ADDR;
      2: a = `CLIC_STACK_DEPTH_ADDR;
      3: a = csr_addr_t'($urandom);
      default: a = BASE + csr_addr_t'($urandom_range(0, VS - 1));
    endcase
    // zero operands often to hit set/clear suppression
    case ($urandom_range(0, 3))
      0: data = '0;
      1: data = word'($urandom_range(0, 31));
      2: data = word'(32'h1 << `CLIC_MIE_BIT);
      default: data = $urandom;
    endcase
    zimm = '0;
    if ($urandom_range(0, 1) == 1) zimm = r'($urandom_range(0, 31));
    // sparse source levels
    src = '0;
    if ($urandom_range(0, 3) == 0) src = VS'($urandom & $urandom & $urandom);
    claim = m_irq && ($urandom_range(0, 2) == 0);
    step(en, a, ops[$urandom_range(0, 5)], zimm, data, src, claim);
  endtask

  initial begin
    seed_ret      = $urandom(SEED);
    cycle_count   = 0;
    clk           = 1'b0;
    arst_n        = 1'b0;
    csr_enable    = 1'b0;
    csr_addr      = '0;
    csr_op        = CSR_NONE;
    rs1_zimm      = '0;
    rs1_data      = '0;
    irq_src       = '0;
    irq_claim     = 1'b0;
    m_mstatus     = `CLIC_MSTATUS_RESET;
    m_mintthresh  = `CLIC_MINTTHRESH_RESET;
    m_stack_depth = `CLIC_STACK_DEPTH_RESET;
    m_irq         = 1'b0;
    m_id          = '0;
    m_prio        = '0;
    for (int i = 0; i < VS; i++) begin
      m_ent[i] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    // reset values through the read port without an access strobe
    step(1'b0, `CLIC_MSTATUS_ADDR, CSR_NONE, '0, '0, '0, 1'b0);
    step(1'b0, `CLIC_MINTTHRESH_ADDR, CSR_NONE, '0, '0, '0, 1'b0);
    step(1'b0, `CLIC_STACK_DEPTH_ADDR, CSR_NONE, '0, '0, '0, 1'b0);
    for (int i = 0; i < VS; i++) begin
      step(1'b0, BASE + csr_addr_t'(i), CSR_NONE, '0, '0, '0, 1'b0);
    end
    // below mstatus nothing is mapped
    step(1'b0, csr_addr_t'($urandom_range(0, 'h2ff)), CSR_NONE, '0, '0, '0, 1'b0);
    repeat (N_RANDOM) random_op();
    step(1'b0, '0, CSR_NONE, '0, '0, '0, 1'b0);
    @(negedge clk);
    check_outputs();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/n_clic.sv
// CLIC top; no vectoring or trap CSRs, stack_depth is a read-only constant
`default_nettype none
`timescale 1ns/1ns

`include "clic_consts.svh"

module n_clic
  import clic_pkg::*;
(
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        csr_enable,
  input  csr_addr_t                   csr_addr,
  input  r                            rs1_zimm,
  input  word                         rs1_data,
  input  csr_op_t                     csr_op,
  output word                         out,
  input  logic [`CLIC_VEC_SIZE-1:0]   irq_src,
  input  logic                        irq_claim,
  output logic                        irq,
  output logic [`CLIC_VEC_WIDTH-1:0]  irq_id,
  output logic [`CLIC_PRIO_WIDTH-1:0] irq_prio
);

  word mstatus_rdata;
  word mstatus_value;
  word mintthresh_rdata;
  word mintthresh_value;
  word stack_depth_rdata;
  word entries_rdata;

  logic [`CLIC_VEC_SIZE-1:0]   pended;
  logic [`CLIC_VEC_SIZE-1:0]   enable;
  logic [`CLIC_PRIO_WIDTH-1:0] prio [`CLIC_VEC_SIZE];

  // global enable lives in mstatus
  csr_reg #(
    .ADDR       (`CLIC_MSTATUS_ADDR),
    .RESET_VALUE(`CLIC_MSTATUS_RESET),
    .WRITABLE   (1'b1)
  ) u_mstatus (
    .clk       (clk),
    .arst_n    (arst_n),
    .csr_enable(csr_enable),
    .csr_addr  (csr_addr),
    .csr_op    (csr_op),
    .rs1_zimm  (rs1_zimm),
    .rs1_data  (rs1_data),
    .rdata     (mstatus_rdata),
    .value     (mstatus_value)
  );

  csr_reg #(
    .ADDR       (`CLIC_MINTTHRESH_ADDR),
    .RESET_VALUE(`CLIC_MINTTHRESH_RESET),
    .WRITABLE   (1'b1)
  ) u_mintthresh (
    .clk       (clk),
    .arst_n    (arst_n),
    .csr_enable(csr_enable),
    .csr_addr  (csr_addr),
    .csr_op    (csr_op),
    .rs1_zimm  (rs1_zimm),
    .rs1_data  (rs1_data),
    .rdata     (mintthresh_rdata),
    .value     (mintthresh_value)
  );

  // constant, value not needed internally
  csr_reg #(
    .ADDR       (`CLIC_STACK_DEPTH_ADDR),
    .RESET_VALUE(`CLIC_STACK_DEPTH_RESET),
    .WRITABLE   (1'b0)
  ) u_stack_depth (
    .clk       (clk),
    .arst_n    (arst_n),
    .csr_enable(csr_enable),
    .csr_addr  (csr_addr),
    .csr_op    (csr_op),
    .rs1_zimm  (rs1_zimm),
    .rs1_data  (rs1_data),
    .rdata     (stack_depth_rdata),
    .value     ()
  );

  // claim clears whatever irq_id currently shows
  clic_entry_bank u_entries (
    .clk       (clk),
    .arst_n    (arst_n),
    .csr_enable(csr_enable),
    .csr_addr  (csr_addr),
    .csr_op    (csr_op),
    .rs1_zimm  (rs1_zimm),
    .rs1_data  (rs1_data),
    .rdata     (entries_rdata),
    .irq_src   (irq_src),
    .irq_claim (irq_claim),
    .claim_id  (irq_id),
    .pended    (pended),
    .enable    (enable),
    .prio      (prio)
  );

  clic_arbiter u_arb (
    .clk      (clk),
    .arst_n   (arst_n),
    .pended   (pended),
    .enable   (enable),
    .prio     (prio),
    .thresh   (mintthresh_value[`CLIC_PRIO_WIDTH-1:0]),
    .mie      (mstatus_value[`CLIC_MIE_BIT]),
    .irq_claim(irq_claim),
    .irq      (irq),
    .irq_id   (irq_id),
    .irq_prio (irq_prio)
  );

  // at most one source addressed, rest read zero
  assign out = mstatus_rdata | mintthresh_rdata | stack_depth_rdata | entries_rdata;

endmodule

`default_nettype wire

// File: design/clic_arbiter.sv
// registered winner select; ties go to the lowest index, id/prio hold while irq is low
`default_nettype none
`timescale 1ns/1ns

`include "clic_consts.svh"

module clic_arbiter (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [`CLIC_VEC_SIZE-1:0]   pended,
  input  logic [`CLIC_VEC_SIZE-1:0]   enable,
  input  logic [`CLIC_PRIO_WIDTH-1:0] prio [`CLIC_VEC_SIZE],
  input  logic [`CLIC_PRIO_WIDTH-1:0] thresh,
  input  logic                        mie,
  input  logic                        irq_claim,
  output logic                        irq,
  output logic [`CLIC_VEC_WIDTH-1:0]  irq_id,
  output logic [`CLIC_PRIO_WIDTH-1:0] irq_prio
);

  localparam int VS = `CLIC_VEC_SIZE;
  localparam int VW = `CLIC_VEC_WIDTH;
  localparam int PW = `CLIC_PRIO_WIDTH;

  logic [VS-1:0] cand;
  logic          found;
  logic [VW-1:0] win_id;
  logic [PW-1:0] win_prio;
  logic          irq_d;

  // pended and enabled
  assign cand = pended & enable;

  // linear scan, strict compare keeps the lower index on a tie
  always_comb begin
    found    = 1'b0;
    win_id   = '0;
    win_prio = '0;
    for (int i = 0; i < VS; i++) begin
      if (cand[i] && (!found || prio[i] > win_prio)) begin
        found    = 1'b1;
        win_id   = VW'(i);
        win_prio = prio[i];
      end
    end
  end

  // threshold and global enable gating
  assign irq_d = found && mie && (win_prio > thresh);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      irq      <= 1'b0;
      irq_id   <= '0;
      irq_prio <= '0;
    end else begin
      irq <= irq_d;
      // keep last winner visible while idle
      if (irq_d) begin
        irq_id   <= win_id;
        irq_prio <= win_prio;
      end
    end
  end

  // core only claims a raised interrupt
  a_claim_with_irq: assert property (
    @(posedge clk) disable iff (!arst_n)
    irq_claim |-> irq
  );

  // registered winner was a candidate in the cycle it was sampled
  a_winner_cand: assert property (
    @(posedge clk) disable iff (!arst_n)
    irq |-> |($past(cand) & (VS'(1) << irq_id))
  );

endmodule

`default_nettype wire

// File: design/clic_entry_bank.sv
// per-vector pended/enable/prio; sources are level-sampled, csr write beats source beats claim
`default_nettype none
`timescale 1ns/1ns

`include "clic_consts.svh"

module clic_entry_bank
  import clic_pkg::*;
(
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        csr_enable,
  input  csr_addr_t                   csr_addr,
  input  csr_op_t                     csr_op,
  input  r                            rs1_zimm,
  input  word                         rs1_data,
  output word                         rdata,
  input  logic [`CLIC_VEC_SIZE-1:0]   irq_src,
  input  logic                        irq_claim,
  input  logic [`CLIC_VEC_WIDTH-1:0]  claim_id,
  output logic [`CLIC_VEC_SIZE-1:0]   pended,
  output logic [`CLIC_VEC_SIZE-1:0]   enable,
  output logic [`CLIC_PRIO_WIDTH-1:0] prio [`CLIC_VEC_SIZE]
);

  localparam int        VS   = `CLIC_VEC_SIZE;
  localparam int        VW   = `CLIC_VEC_WIDTH;
  localparam csr_addr_t BASE = `CLIC_ENTRY_BASE_ADDR;
  // implemented bits: pended, enable, prio
  localparam word CFG_MASK = word'((1 << (`CLIC_PRIO_WIDTH + 2)) - 1);

  entry_cfg_u cfg_q [VS];
  entry_cfg_u cfg_d [VS];
  entry_cfg_u csr_new;
  csr_addr_t  sel_off;
  logic [VW-1:0] sel_idx;
  logic       hit;
  logic       csr_wr;
  word        operand;

  // offset into the entry window
  assign sel_off = csr_addr - BASE;
  assign sel_idx = sel_off[VW-1:0];
  assign hit     = (csr_addr >= BASE) && (sel_off < csr_addr_t'(VS));

  assign operand = csr_operand(csr_op, rs1_zimm, rs1_data);
  assign csr_wr  = csr_enable && hit && csr_writes(csr_op, operand);

  // rmw on the raw view, reserved bits forced to zero
  assign csr_new.raw = csr_next(csr_op, cfg_q[sel_idx].raw, operand) & CFG_MASK;

  always_comb begin
    for (int i = 0; i < VS; i++) begin
      cfg_d[i] = cfg_q[i];
      // lowest priority first, later assignments override
      if (irq_claim && int'(claim_id) == i) begin
        cfg_d[i].fields.pended = 1'b0;
      end
      if (irq_src[i]) begin
        cfg_d[i].fields.pended = 1'b1;
      end
      if (csr_wr && int'(sel_idx) == i) begin
        cfg_d[i] = csr_new;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < VS; i++) begin
        cfg_q[i] <= '0;
      end
    end else begin
      cfg_q <= cfg_d;
    end
  end

  // field view out to the arbiter
  always_comb begin
    for (int i = 0; i < VS; i++) begin
      pended[i] = cfg_q[i].fields.pended;
      enable[i] = cfg_q[i].fields.enable;
      prio[i]   = cfg_q[i].fields.prio;
    end
  end

  assign rdata = hit ? cfg_q[sel_idx].raw : '0;

  a_op_valid: assert property (
    @(posedge clk) disable iff (!arst_n)
    csr_enable |-> csr_op != CSR_NONE
  );

endmodule

`default_nettype wire

// File: design/csr_reg.sv
// single 32-bit CSR; rdata is zero unless addressed, writes land at the next clk edge
`default_nettype none
`timescale 1ns/1ns

module csr_reg
  import clic_pkg::*;
#(
  parameter csr_addr_t ADDR        = '0,
  parameter word       RESET_VALUE = '0,
  parameter bit        WRITABLE    = 1'b1
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      csr_enable,
  input  csr_addr_t csr_addr,
  input  csr_op_t   csr_op,
  input  r          rs1_zimm,
  input  word       rs1_data,
  output word       rdata,
  output word       value
);

  logic hit;
  logic wr_en;
  word  operand;
  word  value_q;

  // address decode, independent of csr_enable so reads are combinational
  assign hit = (csr_addr == ADDR);

  assign operand = csr_operand(csr_op, rs1_zimm, rs1_data);

  // read-only registers drop every write
  assign wr_en = WRITABLE && csr_enable && hit && csr_writes(csr_op, operand);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      value_q <= RESET_VALUE;
    end else if (wr_en) begin
      value_q <= csr_next(csr_op, value_q, operand);
    end
  end

  // zero when unaddressed, top level ORs all sources
  assign rdata = hit ? value_q : '0;
  assign value = value_q;

  // core never strobes an access without an op
  a_op_valid: assert property (
    @(posedge clk) disable iff (!arst_n)
    csr_enable |-> csr_op != CSR_NONE
  );

endmodule

`default_nettype wire

// File: design/clic_pkg.sv
// shared CSR types and Zicsr helpers; immediate ops take a 5-bit zero-extended operand
`default_nettype none

`include "clic_consts.svh"

package clic_pkg;

  typedef logic [31:0] word;
  typedef logic [11:0] csr_addr_t;
  // register index, doubles as zimm
  typedef logic [4:0] r;

  // funct3 encoding of the Zicsr instructions
  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSRRW    = 3'd1,
    CSRRS    = 3'd2,
    CSRRC    = 3'd3,
    CSRRWI   = 3'd5,
    CSRRSI   = 3'd6,
    CSRRCI   = 3'd7
  } csr_op_t;

  // one entry config word, seen raw by the csr path and as fields by the bank
  typedef union packed {
    word raw;
    struct packed {
      logic [31-`CLIC_PRIO_WIDTH-2:0] rsvd;
      logic pended;
      logic enable;
      logic [`CLIC_PRIO_WIDTH-1:0] prio;
    } fields;
  } entry_cfg_u;

  // rs1 or zero-extended zimm
  function automatic word csr_operand(csr_op_t op, r zimm, word data);
    return (op inside {CSRRWI, CSRRSI, CSRRCI}) ? word'(zimm) : data;
  endfunction

  // set/clear with a zero operand leave the register alone
  function automatic logic csr_writes(csr_op_t op, word operand);
    case (op)
      CSRRW, CSRRWI: return 1'b1;
      CSRRS, CSRRSI, CSRRC, CSRRCI: return operand != '0;
      default: return 1'b0;
    endcase
  endfunction

  // read-modify-write result
  function automatic word csr_next(csr_op_t op, word old, word operand);
    case (op)
      CSRRW, CSRRWI: return operand;
      CSRRS, CSRRSI: return old | operand;
      CSRRC, CSRRCI: return old & ~operand;
      default: return old;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: design/clic_consts.svh
// sizes and CSR map constants; entry CSRs are contiguous from the base address, one per vector
`ifndef CLIC_CONSTS_SVH
`define CLIC_CONSTS_SVH

// interrupt vectors
`define CLIC_VEC_SIZE 8
`define CLIC_VEC_WIDTH $clog2(`CLIC_VEC_SIZE)

// priority levels, higher value is more urgent
`define CLIC_PRIO_LEVELS 8
`define CLIC_PRIO_WIDTH $clog2(`CLIC_PRIO_LEVELS)

// csr map
`define CLIC_MSTATUS_ADDR 12'h305
`define CLIC_MINTTHRESH_ADDR 12'h347
`define CLIC_STACK_DEPTH_ADDR 12'h350
// first per-vector config csr
`define CLIC_ENTRY_BASE_ADDR 12'hB00

// reset values
// mstatus comes up with MIE set
`define CLIC_MSTATUS_RESET 32'h8
`define CLIC_MINTTHRESH_RESET 32'h0
// fixed depth, no nesting logic behind it
`define CLIC_STACK_DEPTH_RESET 32'h8

// global interrupt enable in mstatus
`define CLIC_MIE_BIT 3

`endif
